// File: hdl/nf_cpu_pkg.sv
// shared types, decode constants and link records; imported by the execute subsystem modules
package nf_cpu_pkg;

    typedef logic [31 : 0] xlen_t;      // data word, alu result and pc
    typedef logic [31 : 0] instr_t;
    typedef logic [4  : 0] reg_idx_t;

    // decoder key fields sliced from the instruction word
    typedef struct packed {
        logic [1 : 0] it;               // instruction type, 2'b11 for 32-bit rvi
        logic [4 : 0] op;               // opcode bits 6:2
        logic [2 : 0] f3;
        logic [6 : 0] f7;
    } instr_cf;

    localparam logic [1 : 0] RVI       = 2'b11;

    localparam logic [4 : 0] OP_LOAD   = 5'b00000;
    localparam logic [4 : 0] OP_IMM    = 5'b00100;
    localparam logic [4 : 0] OP_STORE  = 5'b01000;
    localparam logic [4 : 0] OP_REG    = 5'b01100;
    localparam logic [4 : 0] OP_LUI    = 5'b01101;
    localparam logic [4 : 0] OP_BRANCH = 5'b11000;
    localparam logic [4 : 0] OP_JALR   = 5'b11001;
    localparam logic [4 : 0] OP_JAL    = 5'b11011;

    typedef enum logic [2 : 0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_LUI} alu_op_e;
    typedef enum logic [2 : 0] {I_NONE, I_SEL, S_SEL, B_SEL, U_SEL, J_SEL} imm_sel_e;
    typedef enum logic [1 : 0] {B_NONE, B_EQ_NEQ, B_UB} branch_e;

    localparam logic SRCB_IMM = 1'b0;   // alu operand b from immediate
    localparam logic SRCB_RD2 = 1'b1;   // alu operand b from rs2
    localparam logic RES_ALU  = 1'b0;
    localparam logic RES_UB   = 1'b1;   // link value pc + 4
    localparam logic RF_ALUR  = 1'b0;
    localparam logic RF_DMEM  = 1'b1;   // load data to rd

    typedef struct packed {
        imm_sel_e imm_sel;
        logic     srcb_sel;
        logic     res_sel;
        branch_e  branch;
        logic     branch_hf;            // 1 for beq, 0 for bne
        logic     branch_src;           // jalr target from rs1
        logic     we_rf;
        logic     we_dm;
        logic     rf_src;
        alu_op_e  alu_op;
    } ctrl_t;

    // input link payload, also the queue entry
    typedef struct packed {
        xlen_t  pc;
        instr_t instr;
    } instr_pkt_t;

    // output link payload, one per retired instruction
    typedef struct packed {
        xlen_t    pc;
        xlen_t    next_pc;
        logic     rd_we;
        reg_idx_t rd;
        xlen_t    rd_data;
        logic     st_we;
        xlen_t    st_addr;
        xlen_t    st_data;
    } retire_t;

endpackage : nf_cpu_pkg

// File: hdl/nf_instr_queue.sv
// instruction FIFO behind the credited input link; returns one credit pulse per pop
`timescale 1ns/100ps

module nf_instr_queue
#(
    parameter int QUEUE_DEPTH = 4
)(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,     // source spent a credit
    input  nf_cpu_pkg::instr_pkt_t instr_in,
    input  logic                   pop,
    output nf_cpu_pkg::instr_pkt_t head,
    output logic                   not_empty,
    output logic                   instr_credit     // registered, one cycle per pop
);

    import nf_cpu_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    instr_pkt_t         mem [QUEUE_DEPTH];
    logic [PTR_W-1 : 0] wr_ptr;
    logic [PTR_W-1 : 0] rd_ptr;
    logic [CNT_W-1 : 0] count;      // occupancy
    logic               push;
    logic               do_pop;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_W-1 : 0] next_ptr(logic [PTR_W-1 : 0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign not_empty = count != '0;
    assign push      = instr_valid && (count != CNT_W'(QUEUE_DEPTH)); // full only at zero credits
    assign do_pop    = pop && not_empty;
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= instr_in;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            instr_credit <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            count        <= count + CNT_W'(push) - CNT_W'(do_pop);
            instr_credit <= do_pop;
        end
    end

endmodule : nf_instr_queue

// File: hdl/nf_control_unit.sv
// combinational rv32i subset decoder, turns an instruction word into the control word
`timescale 1ns/100ps

module nf_control_unit
(
    input  nf_cpu_pkg::instr_t instr,
    output nf_cpu_pkg::ctrl_t  ctrl
);

    import nf_cpu_pkg::*;

    instr_cf        cf;
    logic [8 : 0]   key;            // opcode, funct3, funct7 bit 5

    assign cf.it = instr[1  : 0];
    assign cf.op = instr[6  : 2];
    assign cf.f3 = instr[14 : 12];
    assign cf.f7 = instr[31 : 25];
    assign key   = {cf.op, cf.f3, cf.f7[5]};

    always_comb begin
        // safe defaults, unknown codes retire as no-ops
        ctrl.imm_sel    = I_NONE;
        ctrl.srcb_sel   = SRCB_IMM;
        ctrl.res_sel    = RES_ALU;
        ctrl.branch     = B_NONE;
        ctrl.branch_hf  = 1'b0;
        ctrl.branch_src = 1'b0;
        ctrl.we_rf      = 1'b0;
        ctrl.we_dm      = 1'b0;
        ctrl.rf_src     = RF_ALUR;
        ctrl.alu_op     = ALU_ADD;
        if (cf.it == RVI) begin
            casez (key)
                {OP_REG, 3'b000, 1'b0},
                {OP_REG, 3'b000, 1'b1},
                {OP_REG, 3'b001, 1'b0},
                {OP_REG, 3'b110, 1'b0},
                {OP_REG, 3'b111, 1'b0} : begin  // add sub sll or and
                    ctrl.we_rf    = 1'b1;
                    ctrl.srcb_sel = SRCB_RD2;
                    unique case (cf.f3)
                        3'b001:  ctrl.alu_op = ALU_SLL;
                        3'b110:  ctrl.alu_op = ALU_OR;
                        3'b111:  ctrl.alu_op = ALU_AND;
                        default: ctrl.alu_op = cf.f7[5] ? ALU_SUB : ALU_ADD;
                    endcase
                end
                {OP_IMM, 3'b000, 1'b?},
                {OP_IMM, 3'b110, 1'b?},
                {OP_IMM, 3'b001, 1'b0} : begin  // addi ori slli
                    ctrl.we_rf   = 1'b1;
                    ctrl.imm_sel = I_SEL;
                    unique case (cf.f3)
                        3'b001:  ctrl.alu_op = ALU_SLL;
                        3'b110:  ctrl.alu_op = ALU_OR;
                        default: ctrl.alu_op = ALU_ADD;
                    endcase
                end
                {OP_LOAD, 3'b010, 1'b?} : begin     // lw
                    ctrl.we_rf   = 1'b1;
                    ctrl.imm_sel = I_SEL;
                    ctrl.rf_src  = RF_DMEM;
                end
                {OP_STORE, 3'b010, 1'b?} : begin    // sw
                    ctrl.we_dm   = 1'b1;
                    ctrl.imm_sel = S_SEL;
                end
                {OP_LUI, 4'b????} : begin
                    ctrl.we_rf   = 1'b1;
                    ctrl.imm_sel = U_SEL;
                    ctrl.alu_op  = ALU_LUI;
                end
                {OP_BRANCH, 3'b00?, 1'b?} : begin   // beq bne
                    ctrl.imm_sel   = B_SEL;
                    ctrl.srcb_sel  = SRCB_RD2;
                    ctrl.branch    = B_EQ_NEQ;
                    ctrl.branch_hf = ~cf.f3[0];
                end
                {OP_JAL, 4'b????} : begin
                    ctrl.we_rf   = 1'b1;
                    ctrl.imm_sel = J_SEL;
                    ctrl.res_sel = RES_UB;
                    ctrl.branch  = B_UB;
                end
                {OP_JALR, 3'b000, 1'b?} : begin
                    ctrl.we_rf      = 1'b1;
                    ctrl.imm_sel    = I_SEL;
                    ctrl.res_sel    = RES_UB;
                    ctrl.branch     = B_UB;
                    ctrl.branch_src = 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule : nf_control_unit

// File: hdl/nf_reg_file.sv
// 32 x 32 integer register file, two combinational reads and one clocked write
`timescale 1ns/100ps

module nf_reg_file
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  nf_cpu_pkg::reg_idx_t ra1,
    input  nf_cpu_pkg::reg_idx_t ra2,
    output nf_cpu_pkg::xlen_t    rd1,
    output nf_cpu_pkg::xlen_t    rd2,
    input  logic                 we,
    input  nf_cpu_pkg::reg_idx_t wa,
    input  nf_cpu_pkg::xlen_t    wd
);

    import nf_cpu_pkg::*;

    xlen_t regs [32];   // regs[0] is never written, so x0 reads zero

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

endmodule : nf_reg_file

// File: hdl/nf_data_mem.sv
// word-addressed data memory for lw and sw, combinational read and clocked write
`timescale 1ns/100ps

module nf_data_mem
#(
    parameter int DMEM_WORDS = 64
)(
    input  logic              clk,
    input  logic              rst_n,
    input  nf_cpu_pkg::xlen_t addr,     // byte address, low two bits ignored
    input  logic              we,
    input  nf_cpu_pkg::xlen_t wd,
    output nf_cpu_pkg::xlen_t rd
);

    import nf_cpu_pkg::*;

    localparam int AW = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    xlen_t           mem [DMEM_WORDS];
    logic [AW-1 : 0] widx;

    assign widx = AW'(addr[31 : 2] % DMEM_WORDS);   // wraps modulo the depth
    assign rd   = mem[widx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++)
                mem[i] <= '0;
        end else if (we) begin
            mem[widx] <= wd;
        end
    end

endmodule : nf_data_mem

// File: hdl/nf_exec_stage.sv
// execute datapath: immediate, alu, branch compare, next pc and write-back select
`timescale 1ns/100ps

module nf_exec_stage
(
    input  nf_cpu_pkg::xlen_t  pc,
    input  nf_cpu_pkg::instr_t instr,
    input  nf_cpu_pkg::ctrl_t  ctrl,
    input  nf_cpu_pkg::xlen_t  rs1_data,
    input  nf_cpu_pkg::xlen_t  rs2_data,
    input  nf_cpu_pkg::xlen_t  mem_rdata,
    output nf_cpu_pkg::xlen_t  alu_result,
    output nf_cpu_pkg::xlen_t  rd_data,
    output nf_cpu_pkg::xlen_t  next_pc
);

    import nf_cpu_pkg::*;

    xlen_t imm;
    xlen_t srcb;
    xlen_t pc_plus4;
    xlen_t pc_target;
    xlen_t jalr_sum;
    logic  br_taken;

    always_comb begin
        case (ctrl.imm_sel)
            I_SEL:   imm = {{20{instr[31]}}, instr[31 : 20]};
            S_SEL:   imm = {{20{instr[31]}}, instr[31 : 25], instr[11 : 7]};
            B_SEL:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30 : 25],
                            instr[11 : 8], 1'b0};
            U_SEL:   imm = {instr[31 : 12], 12'b0};
            J_SEL:   imm = {{11{instr[31]}}, instr[31], instr[19 : 12], instr[20],
                            instr[30 : 21], 1'b0};
            default: imm = '0;
        endcase
    end

    assign srcb = (ctrl.srcb_sel == SRCB_RD2) ? rs2_data : imm;

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB: alu_result = rs1_data - srcb;
            ALU_AND: alu_result = rs1_data & srcb;
            ALU_OR:  alu_result = rs1_data | srcb;
            ALU_SLL: alu_result = rs1_data << srcb[4 : 0];
            ALU_LUI: alu_result = srcb;             // upper immediate passes through
            default: alu_result = rs1_data + srcb;
        endcase
    end

    // beq takes on equal, bne on not equal
    assign br_taken  = (ctrl.branch == B_EQ_NEQ) && ((rs1_data == rs2_data) == ctrl.branch_hf);
    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;
    assign jalr_sum  = rs1_data + imm;

    always_comb begin
        next_pc = pc_plus4;
        if (ctrl.branch == B_UB)
            next_pc = ctrl.branch_src ? {jalr_sum[31 : 1], 1'b0} : pc_target;
        else if (br_taken)
            next_pc = pc_target;
    end

    always_comb begin
        if (ctrl.res_sel == RES_UB)
            rd_data = pc_plus4;     // link
        else if (ctrl.rf_src == RF_DMEM)
            rd_data = mem_rdata;
        else
            rd_data = alu_result;
    end

endmodule : nf_exec_stage

// File: hdl/nf_retire_port.sv
// credited output link: credit counter plus the registered retire record
`timescale 1ns/100ps

module nf_retire_port
#(
    parameter int RETIRE_CREDITS = 2
)(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fire_req,       // head instruction executes this cycle
    input  nf_cpu_pkg::retire_t rec_in,
    input  logic                retire_credit,  // sink frees one slot
    output logic                can_fire,
    output logic                retire_valid,
    output nf_cpu_pkg::retire_t retire_out
);

    localparam int CNT_W = $clog2(RETIRE_CREDITS + 1);

    logic [CNT_W-1 : 0] credits;
    logic               fire;

    assign can_fire = credits != '0;
    assign fire     = fire_req && can_fire;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits      <= CNT_W'(RETIRE_CREDITS);
            retire_valid <= 1'b0;
        end else begin
            credits      <= credits - CNT_W'(fire) + CNT_W'(retire_credit);
            retire_valid <= fire;   // exactly one cycle per record
        end
    end

    always_ff @(posedge clk) begin
        if (fire)
            retire_out <= rec_in;
    end

endmodule : nf_retire_port

// File: hdl/nf_exec_top.sv
// top of the rv32i execute subsystem, credited instruction link in and retire link out
`timescale 1ns/100ps

module nf_exec_top
#(
    parameter int QUEUE_DEPTH    = 4,
    parameter int RETIRE_CREDITS = 2,
    parameter int DMEM_WORDS     = 64
)(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  nf_cpu_pkg::instr_pkt_t instr_in,
    output logic                   instr_credit,
    output logic                   retire_valid,
    output nf_cpu_pkg::retire_t    retire_out,
    input  logic                   retire_credit
);

    import nf_cpu_pkg::*;

    instr_pkt_t head;
    logic       not_empty;
    logic       can_fire;
    logic       pop;            // execute, commit and retire the head this cycle
    ctrl_t      ctrl;
    reg_idx_t   rd;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    xlen_t      mem_rdata;
    xlen_t      alu_result;
    xlen_t      rd_data;
    xlen_t      next_pc;
    retire_t    rec;

    assign pop = not_empty && can_fire;
    assign rd  = head.instr[11 : 7];

    nf_instr_queue #(
        .QUEUE_DEPTH    (QUEUE_DEPTH)
    ) u_nf_instr_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr_in       (instr_in),
        .pop            (pop),
        .head           (head),
        .not_empty      (not_empty),
        .instr_credit   (instr_credit)
    );

    nf_control_unit u_nf_control_unit (
        .instr  (head.instr),
        .ctrl   (ctrl)
    );

    nf_reg_file u_nf_reg_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .ra1    (head.instr[19 : 15]),
        .ra2    (head.instr[24 : 20]),
        .rd1    (rs1_data),
        .rd2    (rs2_data),
        .we     (pop && ctrl.we_rf),
        .wa     (rd),
        .wd     (rd_data)
    );

    nf_data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_nf_data_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (alu_result),
        .we         (pop && ctrl.we_dm),
        .wd         (rs2_data),
        .rd         (mem_rdata)
    );

    nf_exec_stage u_nf_exec_stage (
        .pc         (head.pc),
        .instr      (head.instr),
        .ctrl       (ctrl),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .mem_rdata  (mem_rdata),
        .alu_result (alu_result),
        .rd_data    (rd_data),
        .next_pc    (next_pc)
    );

    always_comb begin
        rec.pc      = head.pc;
        rec.next_pc = next_pc;
        rec.rd_we   = ctrl.we_rf && (rd != '0);    // x0 writes are not reported
        rec.rd      = rd;
        rec.rd_data = rd_data;
        rec.st_we   = ctrl.we_dm;
        rec.st_addr = alu_result;
        rec.st_data = rs2_data;
    end

    nf_retire_port #(
        .RETIRE_CREDITS (RETIRE_CREDITS)
    ) u_nf_retire_port (
        .clk            (clk),
        .rst_n          (rst_n),
        .fire_req       (pop),
        .rec_in         (rec),
        .retire_credit  (retire_credit),
        .can_fire       (can_fire),
        .retire_valid   (retire_valid),
        .retire_out     (retire_out)
    );

endmodule : nf_exec_top

// File: dv/nf_exec_assertions.sv
// concurrent checks on the retire link credits and reset state, bound into the retire port
`timescale 1ns/100ps

module nf_exec_assertions
#(
    parameter int RETIRE_CREDITS = 2,
    parameter int CNT_W          = $clog2(RETIRE_CREDITS + 1)
)(
    input logic               clk,
    input logic               rst_n,
    input logic               retire_valid,
    input logic               retire_credit,
    input logic [CNT_W-1 : 0] credits
);

    int outstanding;    // records delivered to the sink, not yet credited back

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            outstanding <= 0;
        else
            outstanding <= outstanding + int'(retire_valid) - int'(retire_credit);
    end

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CNT_W'(RETIRE_CREDITS))
        else $error("retire credit count above its limit");

    no_extra_credit: assert property (@(posedge clk) disable iff (!rst_n)
        (credits == CNT_W'(RETIRE_CREDITS)) |-> !retire_credit)
        else $error("credit returned with no record outstanding");

    // a record on the link still holds its credit
    credit_conserved: assert property (@(posedge clk) disable iff (!rst_n)
        int'(credits) + outstanding + int'(retire_valid) == RETIRE_CREDITS)
        else $error("retire credits and outstanding records do not add up");

    reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> (!retire_valid && credits == CNT_W'(RETIRE_CREDITS)))
        else $error("retire port not in reset state after reset");

endmodule : nf_exec_assertions

// File: dv/tb_nf_exec_top.sv
// testbench for the execute subsystem, replays the stimulus file over both credited links
`timescale 1ns/100ps

module tb_nf_exec_top;

    import nf_cpu_pkg::*;

    localparam int QUEUE_DEPTH    = 4;
    localparam int RETIRE_CREDITS = 2;
    localparam int DMEM_WORDS     = 64;
    localparam int HOLD_AFTER     = 8;      // records retired before credits are held
    localparam int HOLD_CYCLES    = 40;

    logic        clk           = 1'b0;
    logic        rst_n         = 1'b0;
    logic        instr_valid   = 1'b0;
    instr_pkt_t  instr_in      = '0;
    logic        instr_credit;
    logic        retire_valid;
    retire_t     retire_out;
    logic        retire_credit = 1'b0;

    instr_pkt_t  pkt_q[$];
    retire_t     exp_q[$];
    int          n_instr       = 0;
    int          sent_total    = 0;
    int          valid_seen    = 0;     // instr_valid cycles seen at the DUT
    int          credits_back  = 0;     // instr_credit pulses seen
    int          rec_idx       = 0;
    int          owed          = 0;     // retire credits still to return
    int          held_recs     = 0;
    logic        hold_credits  = 1'b0;

    always #2 clk = ~clk;

    nf_exec_top #(
        .QUEUE_DEPTH    (QUEUE_DEPTH),
        .RETIRE_CREDITS (RETIRE_CREDITS),
        .DMEM_WORDS     (DMEM_WORDS)
    ) u_nf_exec_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr_in       (instr_in),
        .instr_credit   (instr_credit),
        .retire_valid   (retire_valid),
        .retire_out     (retire_out),
        .retire_credit  (retire_credit)
    );

    bind nf_retire_port nf_exec_assertions #(
        .RETIRE_CREDITS (RETIRE_CREDITS)
    ) u_nf_exec_assertions (
        .clk            (clk),
        .rst_n          (rst_n),
        .retire_valid   (retire_valid),
        .retire_credit  (retire_credit),
        .credits        (credits)
    );

    task automatic fail_check(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic load_stimulus();
        int          fd;
        int          code;
        string       line;
        logic [31:0] f_pc, f_instr, f_npc, f_rdwe, f_rd, f_rdd, f_stwe, f_sta, f_std;
        instr_pkt_t  pkt;
        retire_t     exp;
        fd = $fopen("dv/nf_exec_stimulus.txt", "r");
        if (fd == 0)
            abort_run("cannot open the stimulus file dv/nf_exec_stimulus.txt");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() >= 8 && line.substr(0, 0) != "#") begin
                code = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_pc, f_instr, f_npc,
                               f_rdwe, f_rd, f_rdd, f_stwe, f_sta, f_std);
                if (code != 9)
                    abort_run($sformatf("malformed stimulus line: %s", line));
                pkt.pc       = f_pc;
                pkt.instr    = f_instr;
                exp.pc       = f_pc;
                exp.next_pc  = f_npc;
                exp.rd_we    = f_rdwe[0];
                exp.rd       = f_rd[4:0];
                exp.rd_data  = f_rdd;
                exp.st_we    = f_stwe[0];
                exp.st_addr  = f_sta;
                exp.st_data  = f_std;
                pkt_q.push_back(pkt);
                exp_q.push_back(exp);
            end
        end
        $fclose(fd);
        n_instr = pkt_q.size();
    endtask

    task automatic wait_records(input int target, input int limit);
        int cycles;
        cycles = 0;
        while (rec_idx < target) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit)
                abort_run($sformatf("timeout waiting for %0d retire records", target));
        end
    endtask

    // source side of the input link, one packet per credit
    task automatic send_all();
        int i;
        int idle;
        int waited;
        for (i = 0; i < n_instr; i++) begin
            idle = $urandom_range(2, 0);
            repeat (idle) begin
                @(posedge clk);
                instr_valid <= 1'b0;
            end
            @(posedge clk);
            waited = 0;
            while (QUEUE_DEPTH + credits_back - sent_total <= 0) begin
                instr_valid <= 1'b0;
                waited++;
                if (waited > 500)
                    abort_run("timeout: no input credit came back to the source");
                @(posedge clk);
            end
            instr_valid <= 1'b1;
            instr_in    <= pkt_q[i];
            sent_total  <= sent_total + 1;
        end
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic withhold_credits();
        wait_records(HOLD_AFTER, 1000);
        @(posedge clk);
        hold_credits <= 1'b1;
        repeat (HOLD_CYCLES) @(posedge clk);
        assert (held_recs <= RETIRE_CREDITS)
            else fail_check($sformatf("%0d records retired while credits were held", held_recs));
        assert (!retire_valid)
            else fail_check("retire_valid still active after credits ran out");
        hold_credits <= 1'b0;
    endtask

    task automatic check_record(input int idx);
        retire_t exp;
        assert (idx < n_instr)
            else fail_check("more retire records than instructions sent");
        exp = exp_q[idx];
        assert (retire_out.pc == exp.pc)
            else fail_check($sformatf("record %0d pc %h, expected %h", idx, retire_out.pc, exp.pc));
        assert (retire_out.next_pc == exp.next_pc)
            else fail_check($sformatf("record %0d next_pc %h, expected %h",
                                      idx, retire_out.next_pc, exp.next_pc));
        assert (retire_out.rd_we == exp.rd_we)
            else fail_check($sformatf("record %0d rd_we %b, expected %b",
                                      idx, retire_out.rd_we, exp.rd_we));
        if (exp.rd_we) begin
            assert (retire_out.rd == exp.rd)
                else fail_check($sformatf("record %0d rd %0d, expected %0d",
                                          idx, retire_out.rd, exp.rd));
            assert (retire_out.rd_data == exp.rd_data)
                else fail_check($sformatf("record %0d rd_data %h, expected %h",
                                          idx, retire_out.rd_data, exp.rd_data));
        end
        assert (retire_out.st_we == exp.st_we)
            else fail_check($sformatf("record %0d st_we %b, expected %b",
                                      idx, retire_out.st_we, exp.st_we));
        if (exp.st_we) begin
            assert (retire_out.st_addr == exp.st_addr)
                else fail_check($sformatf("record %0d st_addr %h, expected %h",
                                          idx, retire_out.st_addr, exp.st_addr));
            assert (retire_out.st_data == exp.st_data)
                else fail_check($sformatf("record %0d st_data %h, expected %h",
                                          idx, retire_out.st_data, exp.st_data));
        end
    endtask

    // sink side of the output link plus input credit counting
    always @(posedge clk) begin : sink
        int owed_now;
        owed_now = owed + (retire_valid ? 1 : 0);
        retire_credit <= 1'b0;
        if (instr_credit)
            credits_back <= credits_back + 1;
        if (instr_valid) begin
            assert (valid_seen < QUEUE_DEPTH + credits_back)
                else fail_check($sformatf("instr_valid with no input credit left, %0d sent",
                                          valid_seen));
            valid_seen <= valid_seen + 1;
        end
        if (rst_n && sent_total == 0)
            assert (!retire_valid && !instr_credit)
                else fail_check("link active before the first instruction was sent");
        if (retire_valid) begin
            check_record(rec_idx);
            rec_idx <= rec_idx + 1;
            if (hold_credits)
                held_recs <= held_recs + 1;
        end
        if (!hold_credits && owed_now > 0 && $urandom_range(3, 0) != 0) begin
            retire_credit <= 1'b1;      // random return delay
            owed          <= owed_now - 1;
        end else begin
            owed          <= owed_now;
        end
    end

    initial begin
        void'($urandom(64970));
        load_stimulus();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        fork
            send_all();
            withhold_credits();
        join
        wait_records(n_instr, 2000);
        assert (credits_back == n_instr)
            else fail_check($sformatf("%0d instr_credit pulses for %0d instructions",
                                      credits_back, n_instr));
        $display("TEST OK");
        $finish;
    end

endmodule : tb_nf_exec_top

// File: files.f
hdl/nf_cpu_pkg.sv
hdl/nf_instr_queue.sv
hdl/nf_control_unit.sv
hdl/nf_reg_file.sv
hdl/nf_data_mem.sv
hdl/nf_exec_stage.sv
hdl/nf_retire_port.sv
hdl/nf_exec_top.sv
dv/nf_exec_assertions.sv
dv/tb_nf_exec_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_nf_exec_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation stopped without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/nf_exec_stimulus.txt
# pc instr next_pc rd_we rd rd_data st_we st_addr st_data (all hex, one instruction per line)
# expected fields assume zeroed registers and data memory at the first line
00000000 00500093 00000004 1 01 00000005 0 00000000 00000000
00000004 ffd00113 00000008 1 02 fffffffd 0 00000000 00000000
00000008 002081b3 0000000c 1 03 00000002 0 00000000 00000000
0000000c 40208233 00000010 1 04 00000008 0 00000000 00000000
00000010 0020f2b3 00000014 1 05 00000005 0 00000000 00000000
00000014 00126333 00000018 1 06 0000000d 0 00000000 00000000
00000018 003093b3 0000001c 1 07 00000014 0 00000000 00000000
0000001c 0f006413 00000020 1 08 000000f0 0 00000000 00000000
00000020 00409493 00000024 1 09 00000050 0 00000000 00000000
00000024 12345537 00000028 1 0a 12345000 0 00000000 00000000
00000028 00622223 0000002c 0 00 00000000 1 0000000c 0000000d
0000002c 00a02023 00000030 0 00 00000000 1 00000000 12345000
00000030 00c02583 00000034 1 0b 0000000d 0 00000000 00000000
00000034 ff822603 00000038 1 0c 12345000 0 00000000 00000000
00000038 00708013 0000003c 0 00 00000000 0 00000000 00000000
0000003c 001006b3 00000040 1 0d 00000005 0 00000000 00000000
00000040 00508863 00000050 0 00 00000000 0 00000000 00000000
00000050 00509863 00000054 0 00 00000000 0 00000000 00000000
00000054 fe209ce3 0000004c 0 00 00000000 0 00000000 00000000
0000004c 00208463 00000050 0 00 00000000 0 00000000 00000000
00000050 0200076f 00000070 1 0e 00000054 0 00000000 00000000
00000070 001407e7 000000f0 1 0f 00000074 0 00000000 00000000
000000f0 ff1ff06f 000000e0 0 00 00000000 0 00000000 00000000
000000e0 0000000f 000000e4 0 00 00000000 0 00000000 00000000
000000e4 00e78833 000000e8 1 10 000000c8 0 00000000 00000000
